// ==== hdl/dcache_consts.svh ====
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// address split: tag 31:15, set 14:6, word 5:3
`define DCACHE_ADDR_W    32
`define DCACHE_WORD_W    64
`define DCACHE_LINE_W    512
`define DCACHE_BANKS     8     // words per line
`define DCACHE_WAYS      2
`define DCACHE_INDEX_W   9
`define DCACHE_TAG_W     17
`define DCACHE_OFFSET_W  6     // byte offset within a line

`endif

// ==== hdl/dcache_pkg.sv ====
`include "dcache_consts.svh"

package dcache_pkg;

    typedef logic [`DCACHE_WORD_W-1:0] word_t;

    // bank 0 sits in the low 64 bits
    typedef word_t [`DCACHE_BANKS-1:0] line_t;

    typedef logic [`DCACHE_INDEX_W-1:0] index_t;
    typedef logic [`DCACHE_TAG_W-1:0] tag_t;
    typedef logic [$clog2(`DCACHE_WAYS)-1:0] way_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

    // one RAM word holds the whole set
    typedef struct packed {
        logic rr;                               // next round-robin victim
        tag_entry_t [`DCACHE_WAYS-1:0] way;
    } tag_set_t;

endpackage

// ==== hdl/dcache_sram.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_sram #(
    parameter type entry_t = logic,
    parameter int depth = 1 << `DCACHE_INDEX_W
) (
    input  logic               clock,
    input  logic               en,
    input  logic               we,
    input  dcache_pkg::index_t addr,
    input  entry_t             wdata,
    output entry_t             rdata
);

    entry_t mem [depth];

    // read data shows up one cycle after en, holds until the next read
    always_ff @(posedge clock) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

// ==== hdl/dcache_ifs.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

interface tag_lookup_if;
    import dcache_pkg::*;

    index_t index;
    logic   rd_en;
    logic   wr_en;
    way_t   wr_way;
    logic   wr_dirty;
    tag_t   wr_tag;         // tag of the current access

    // probe results, valid the cycle after rd_en
    logic   set_hit;
    way_t   hit_way;
    way_t   victim_way;
    logic   victim_valid;
    logic   victim_dirty;
    tag_t   victim_tag;

    modport ctrl (
        output index, rd_en, wr_en, wr_way, wr_dirty, wr_tag,
        input  set_hit, hit_way, victim_way, victim_valid, victim_dirty, victim_tag
    );

    modport lookup (
        input  index, rd_en, wr_en, wr_way, wr_dirty, wr_tag,
        output set_hit, hit_way, victim_way, victim_valid, victim_dirty, victim_tag
    );
endinterface

interface data_store_if;
    import dcache_pkg::*;

    index_t index;
    logic   rd_en;
    logic   wr_en;
    way_t   wr_way;
    line_t  wr_line;
    line_t  rd_lines [`DCACHE_WAYS];    // both ways, cycle after rd_en

    modport ctrl (output index, rd_en, wr_en, wr_way, wr_line, input rd_lines);
    modport store (input index, rd_en, wr_en, wr_way, wr_line, output rd_lines);
endinterface

// ==== hdl/dcache_tag_lookup.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_tag_lookup (
    input  logic         clock,
    input  logic         reset_n,
    tag_lookup_if.lookup tags
);
    import dcache_pkg::*;

    localparam int sets = 1 << `DCACHE_INDEX_W;

    tag_set_t rd_set;
    tag_set_t wr_set;
    tag_t     cur_tag;
    logic [`DCACHE_WAYS-1:0] valid_q [sets];    // RAM content is garbage until written
    logic [`DCACHE_WAYS-1:0] set_valid;
    logic [`DCACHE_WAYS-1:0] way_valid;
    logic [`DCACHE_WAYS-1:0] way_hit;
    logic     rr;

    dcache_sram #(.entry_t(tag_set_t), .depth(sets)) tag_ram (
        .clock (clock),
        .en    (tags.rd_en | tags.wr_en),
        .we    (tags.wr_en),
        .addr  (tags.index),
        .wdata (wr_set),
        .rdata (rd_set)
    );

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            set_valid <= '0;
            for (int s = 0; s < sets; s++) begin
                valid_q[s] <= '0;
            end
        end else if (tags.wr_en) begin
            valid_q[tags.index][tags.wr_way] <= 1'b1;
        end else if (tags.rd_en) begin
            set_valid <= valid_q[tags.index];   // lines up with the RAM output
        end
    end

    always_ff @(posedge clock) begin
        if (tags.rd_en) begin
            cur_tag <= tags.wr_tag;
        end
    end

    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            way_valid[w] = set_valid[w] & rd_set.way[w].valid;
            way_hit[w]   = way_valid[w] & (rd_set.way[w].tag == cur_tag);
        end
    end

    // a set never written has no rr bit yet, start at way 0
    assign rr = (|set_valid) ? rd_set.rr : 1'b0;

    // first invalid way, else round robin
    always_comb begin
        if (!way_valid[0]) begin
            tags.victim_way = 1'b0;
        end else if (!way_valid[1]) begin
            tags.victim_way = 1'b1;
        end else begin
            tags.victim_way = rr;
        end
    end

    assign tags.set_hit      = |way_hit;
    assign tags.hit_way      = way_hit[1];
    assign tags.victim_valid = way_valid[tags.victim_way];
    assign tags.victim_dirty = tags.victim_valid & rd_set.way[tags.victim_way].dirty;
    assign tags.victim_tag   = rd_set.way[tags.victim_way].tag;

    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            wr_set.way[w].valid = way_valid[w];
            wr_set.way[w].dirty = way_valid[w] & rd_set.way[w].dirty;
            wr_set.way[w].tag   = rd_set.way[w].tag;
        end
        wr_set.way[tags.wr_way] = '{valid: 1'b1, dirty: tags.wr_dirty, tag: tags.wr_tag};
        // a miss landing on a valid way used the rr pick
        wr_set.rr = rr ^ (~tags.set_hit & way_valid[tags.wr_way]);
    end

endmodule

// ==== hdl/dcache_data_store.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_data_store (
    input  logic        clock,
    data_store_if.store data
);
    import dcache_pkg::*;

    localparam int sets = 1 << `DCACHE_INDEX_W;

    // one line RAM per way, both read together
    for (genvar w = 0; w < `DCACHE_WAYS; w++) begin : g_way
        logic way_wr;

        assign way_wr = data.wr_en & (data.wr_way == w);   // only the selected way

        dcache_sram #(.entry_t(line_t), .depth(sets)) line_ram (
            .clock (clock),
            .en    (data.rd_en | way_wr),
            .we    (way_wr),
            .addr  (data.index),
            .wdata (data.wr_line),
            .rdata (data.rd_lines[w])
        );
    end

endmodule

// ==== hdl/dcache_ctrl.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_ctrl (
    input  logic                      clock,
    input  logic                      reset_n,
    input  logic                      req_valid,
    output logic                      req_ready,
    input  logic [`DCACHE_ADDR_W-1:0] req_addr,
    input  logic                      req_write,
    input  dcache_pkg::word_t         req_wdata,
    input  dcache_pkg::word_t         req_wmask,
    output logic                      resp_done,
    output dcache_pkg::word_t         resp_rdata,
    output logic                      mem_valid,
    output logic                      mem_write,
    output logic [`DCACHE_ADDR_W-1:0] mem_addr,
    output dcache_pkg::line_t         mem_wdata,
    input  logic                      mem_ready,
    input  logic                      mem_done,
    input  dcache_pkg::line_t         mem_rdata,
    tag_lookup_if.ctrl                tags,
    data_store_if.ctrl                data
);
    import dcache_pkg::*;

    localparam int word_lsb = $clog2(`DCACHE_WORD_W / 8);
    localparam int bank_w   = $clog2(`DCACHE_BANKS);

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_write_back,
        st_fetch,
        st_refill
    } state_t;

    state_t state;
    logic   wait_done;          // request taken, waiting for mem_done
    logic   accept;
    logic [`DCACHE_ADDR_W-1:0] cur_addr;
    logic [`DCACHE_ADDR_W-1:0] addr_q;
    logic   write_q;
    word_t  wdata_q;
    word_t  wmask_q;
    logic [`DCACHE_ADDR_W-1:0] victim_addr_q;
    line_t  victim_line_q;
    way_t   victim_way_q;
    line_t  fill_line_q;
    logic [bank_w-1:0] bank;
    line_t  hit_line;

    function automatic line_t merge_word(line_t line, logic [bank_w-1:0] sel,
                                         word_t wdata, word_t wmask);
        line_t merged;
        merged = line;
        merged[sel] = (wdata & wmask) | (line[sel] & ~wmask);
        return merged;
    endfunction

    assign req_ready = (state == st_idle);
    assign accept    = req_valid & req_ready;
    assign cur_addr  = req_ready ? req_addr : addr_q;   // live address only while idle
    assign bank      = addr_q[word_lsb +: bank_w];
    assign hit_line  = data.rd_lines[tags.hit_way];

    assign tags.index  = cur_addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
    assign tags.rd_en  = accept;
    assign tags.wr_tag = cur_addr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
    assign data.index  = cur_addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
    assign data.rd_en  = accept;

    assign mem_valid = (state == st_write_back || state == st_fetch) && !wait_done;
    assign mem_write = (state == st_write_back);
    assign mem_addr  = mem_write ? victim_addr_q :
                       {addr_q[`DCACHE_ADDR_W-1:`DCACHE_OFFSET_W], {`DCACHE_OFFSET_W{1'b0}}};
    assign mem_wdata = victim_line_q;

    always_comb begin
        tags.wr_en    = 1'b0;
        tags.wr_way   = victim_way_q;
        tags.wr_dirty = write_q;
        data.wr_en    = 1'b0;
        data.wr_way   = victim_way_q;
        data.wr_line  = fill_line_q;
        resp_done     = 1'b0;
        resp_rdata    = '0;
        if (state == st_lookup && tags.set_hit) begin
            resp_done = 1'b1;
            if (write_q) begin
                tags.wr_en   = 1'b1;
                tags.wr_way  = tags.hit_way;
                data.wr_en   = 1'b1;
                data.wr_way  = tags.hit_way;
                data.wr_line = merge_word(hit_line, bank, wdata_q, wmask_q);
            end else begin
                resp_rdata = hit_line[bank];
            end
        end else if (state == st_refill) begin
            resp_done  = 1'b1;
            tags.wr_en = 1'b1;
            data.wr_en = 1'b1;
            resp_rdata = write_q ? '0 : fill_line_q[bank];
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state     <= st_idle;
            wait_done <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) state <= st_lookup;
                end
                st_lookup: begin
                    if (tags.set_hit) begin
                        state <= st_idle;
                    end else if (tags.victim_valid && tags.victim_dirty) begin
                        state <= st_write_back;
                    end else begin
                        state <= st_fetch;
                    end
                end
                st_write_back, st_fetch: begin
                    if (!wait_done && mem_ready) begin
                        wait_done <= 1'b1;
                    end else if (wait_done && mem_done) begin
                        wait_done <= 1'b0;
                        state     <= (state == st_write_back) ? st_fetch : st_refill;
                    end
                end
                default: state <= st_idle;     // refill lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            addr_q  <= req_addr;
            write_q <= req_write;
            wdata_q <= req_wdata;
            wmask_q <= req_wmask;
        end
        if (state == st_lookup) begin
            victim_way_q  <= tags.victim_way;
            victim_line_q <= data.rd_lines[tags.victim_way];
            victim_addr_q <= {tags.victim_tag, addr_q[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W],
                              {`DCACHE_OFFSET_W{1'b0}}};
        end
        // store miss merges into the fetched line before refill
        if (state == st_fetch && wait_done && mem_done) begin
            fill_line_q <= write_q ? merge_word(mem_rdata, bank, wdata_q, wmask_q) : mem_rdata;
        end
    end

endmodule

// ==== hdl/dcache_top.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_top (
    input  logic                      clock,
    input  logic                      reset_n,
    input  logic                      req_valid,
    output logic                      req_ready,
    input  logic [`DCACHE_ADDR_W-1:0] req_addr,
    input  logic                      req_write,
    input  dcache_pkg::word_t         req_wdata,
    input  dcache_pkg::word_t         req_wmask,
    output logic                      resp_done,
    output dcache_pkg::word_t         resp_rdata,
    output logic                      mem_valid,
    output logic                      mem_write,
    output logic [`DCACHE_ADDR_W-1:0] mem_addr,
    output dcache_pkg::line_t         mem_wdata,
    input  logic                      mem_ready,
    input  logic                      mem_done,
    input  dcache_pkg::line_t         mem_rdata
);

    tag_lookup_if tags_if ();
    data_store_if data_if ();

    dcache_ctrl ctrl0 (
        .clock      (clock),
        .reset_n    (reset_n),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_addr   (req_addr),
        .req_write  (req_write),
        .req_wdata  (req_wdata),
        .req_wmask  (req_wmask),
        .resp_done  (resp_done),
        .resp_rdata (resp_rdata),
        .mem_valid  (mem_valid),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_ready  (mem_ready),
        .mem_done   (mem_done),
        .mem_rdata  (mem_rdata),
        .tags       (tags_if.ctrl),
        .data       (data_if.ctrl)
    );

    // tag probe and line read run side by side
    dcache_tag_lookup tags0 (
        .clock   (clock),
        .reset_n (reset_n),
        .tags    (tags_if.lookup)
    );

    dcache_data_store data0 (
        .clock (clock),
        .data  (data_if.store)
    );

endmodule

// ==== verif/dcache_properties.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_properties (
    input logic                      clock,
    input logic                      reset_n,
    input logic                      req_valid,
    input logic                      req_ready,
    input logic                      resp_done,
    input logic                      mem_valid,
    input logic                      mem_write,
    input logic [`DCACHE_ADDR_W-1:0] mem_addr,
    input dcache_pkg::line_t         mem_wdata,
    input logic                      mem_ready
);
    import dcache_pkg::*;

    int fails = 0;      // failed assertions so far

    // request held until the memory takes it
    mem_hold: assert property (@(posedge clock) disable iff (!reset_n)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_write)
            && $stable(mem_addr) && $stable(mem_wdata))
        else begin
            fails++;
            $error("memory request changed before mem_ready");
        end

    done_pulse: assert property (@(posedge clock) disable iff (!reset_n)
        resp_done |=> !resp_done)
        else begin
            fails++;
            $error("resp_done longer than one cycle");
        end

    ready_drop: assert property (@(posedge clock) disable iff (!reset_n)
        req_valid && req_ready |=> !req_ready)
        else begin
            fails++;
            $error("req_ready high right after acceptance");
        end

    ready_at_done: assert property (@(posedge clock) disable iff (!reset_n)
        resp_done |-> !req_ready)
        else begin
            fails++;
            $error("req_ready high during resp_done");
        end

    line_aligned: assert property (@(posedge clock) disable iff (!reset_n)
        mem_valid |-> mem_addr[`DCACHE_OFFSET_W-1:0] == '0)
        else begin
            fails++;
            $error("mem_addr not line aligned");
        end

endmodule

bind dcache_top dcache_properties props0 (.*);

// ==== verif/dcache_tb.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_tb;
    import dcache_pkg::*;

    localparam int cycle_limit = 400 * 60;     // accesses times worst-case cycles each
    localparam int kind_any = 0;
    localparam int kind_hit = 1;
    localparam int kind_miss_clean = 2;
    localparam int kind_miss_dirty = 3;

    typedef struct packed {
        logic [`DCACHE_ADDR_W-1:0] addr;
        logic  write;
        word_t wdata;
        word_t wmask;
    } req_t;

    logic clock;
    logic reset_n;
    logic req_valid, req_ready, req_write, resp_done;
    logic [`DCACHE_ADDR_W-1:0] req_addr;
    word_t req_wdata, req_wmask, resp_rdata;
    logic mem_valid, mem_write, mem_ready, mem_done;
    logic [`DCACHE_ADDR_W-1:0] mem_addr;
    line_t mem_wdata, mem_rdata;

    int unsigned cycles = 0;
    int unsigned mem_reads = 0;
    int unsigned mem_writes = 0;
    int unsigned last_rd_cycle = 0;
    int unsigned last_wr_cycle = 0;
    logic [`DCACHE_ADDR_W-1:0] last_rd_addr, last_wr_addr;
    logic mem_busy = 1'b0;
    logic pend_write;
    logic [`DCACHE_ADDR_W-1:0] pend_addr;
    int unsigned ready_wait = 0;
    int unsigned done_wait = 0;

    word_t golden [logic [`DCACHE_ADDR_W-1:0]];     // keyed by word address
    line_t mem_lines [logic [`DCACHE_ADDR_W-1:0]];  // keyed by line address
    req_t  sent [$];

    dcache_top dut0 (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic check(input string name, input logic [511:0] actual,
                         input logic [511:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    // memory contents before any write-back
    function automatic word_t init_word(input logic [`DCACHE_ADDR_W-1:0] a);
        return {~a, a ^ 32'h5a5a_c3c3};
    endfunction

    function automatic word_t golden_word(input logic [`DCACHE_ADDR_W-1:0] a);
        return golden.exists(a) ? golden[a] : init_word(a);
    endfunction

    function automatic line_t golden_line(input logic [`DCACHE_ADDR_W-1:0] a);
        line_t l;
        for (int b = 0; b < `DCACHE_BANKS; b++) begin
            l[b] = golden_word({a[`DCACHE_ADDR_W-1:`DCACHE_OFFSET_W], 3'(b), 3'b000});
        end
        return l;
    endfunction

    function automatic line_t fetch_line(input logic [`DCACHE_ADDR_W-1:0] a);
        line_t l;
        if (mem_lines.exists(a)) begin
            return mem_lines[a];
        end
        for (int b = 0; b < `DCACHE_BANKS; b++) begin
            l[b] = init_word({a[`DCACHE_ADDR_W-1:`DCACHE_OFFSET_W], 3'(b), 3'b000});
        end
        return l;
    endfunction

    // expected read word, masked write into the golden words
    function automatic word_t ref_access(input req_t r);
        logic [`DCACHE_ADDR_W-1:0] wa;
        word_t old;
        wa  = {r.addr[`DCACHE_ADDR_W-1:3], 3'b000};
        old = golden_word(wa);
        if (r.write) begin
            golden[wa] = (r.wdata & r.wmask) | (old & ~r.wmask);
            return '0;
        end
        return old;
    endfunction

    function automatic logic [`DCACHE_ADDR_W-1:0] make_addr(input logic [`DCACHE_TAG_W-1:0] tag,
            input logic [`DCACHE_INDEX_W-1:0] set, input logic [2:0] word);
        return {tag, set, word, 3'b000};
    endfunction

    // cycle count, timeout and assertion watch
    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run exceeded %0d cycles", cycle_limit);
            $display("TESTBENCH FAILED");
            $fatal(1, "timeout");
        end else if (dut0.props0.fails != 0) begin
            $display("a bound assertion on the DUT failed");
            $display("TESTBENCH FAILED");
            $fatal(1, "assertion");
        end
    end

    // line memory, random ready and done delays
    always @(posedge clock) begin
        mem_done <= 1'b0;
        if (mem_busy) begin
            if (done_wait == 0) begin
                mem_done <= 1'b1;
                mem_busy <= 1'b0;
                if (!pend_write) mem_rdata <= fetch_line(pend_addr);
            end else begin
                done_wait <= done_wait - 1;
            end
        end else if (mem_valid && mem_ready) begin     // taken at this edge
            mem_ready  <= 1'b0;
            mem_busy   <= 1'b1;
            pend_write <= mem_write;
            pend_addr  <= mem_addr;
            done_wait  <= $urandom_range(5);
            ready_wait <= $urandom_range(5);
            if (mem_write) begin
                check("mem_wdata", mem_wdata, golden_line(mem_addr));
                mem_lines[mem_addr] = mem_wdata;
                mem_writes    <= mem_writes + 1;
                last_wr_addr  <= mem_addr;
                last_wr_cycle <= cycles;
            end else begin
                mem_reads     <= mem_reads + 1;
                last_rd_addr  <= mem_addr;
                last_rd_cycle <= cycles;
            end
        end else if (mem_valid) begin
            if (ready_wait == 0) mem_ready <= 1'b1;
            else ready_wait <= ready_wait - 1;
        end
    end

    // compare every response with the reference
    always @(posedge clock) begin
        req_t  r;
        word_t expected;
        if (resp_done) begin
            if (sent.size() == 0) begin
                $display("resp_done pulsed with no access in flight");
                $display("TESTBENCH FAILED");
                $fatal(1, "unexpected response");
            end else begin
                r = sent.pop_front();
                expected = ref_access(r);
                check("resp_rdata", resp_rdata, expected);
            end
        end
    end

    task automatic run_access(input logic [`DCACHE_ADDR_W-1:0] addr, input logic write,
            input word_t wdata, input word_t wmask, input int kind,
            input logic [`DCACHE_ADDR_W-1:0] wb_addr);
        int unsigned reads0;
        int unsigned writes0;
        int unsigned start;
        logic [`DCACHE_ADDR_W-1:0] line_addr;
        reads0    = mem_reads;
        writes0   = mem_writes;
        line_addr = {addr[`DCACHE_ADDR_W-1:`DCACHE_OFFSET_W], 6'b0};
        req_valid <= 1'b1;
        req_addr  <= addr;
        req_write <= write;
        req_wdata <= wdata;
        req_wmask <= wmask;
        do @(posedge clock); while (!req_ready);
        req_valid <= 1'b0;
        sent.push_back('{addr, write, wdata, wmask});
        start = cycles;
        do @(posedge clock); while (!resp_done);
        if (kind == kind_hit) begin
            check("hit latency", cycles - start, 1);
            check("mem read count", mem_reads - reads0, 0);
            check("mem write count", mem_writes - writes0, 0);
        end else if (kind != kind_any) begin
            check("mem read count", mem_reads - reads0, 1);
            check("mem_addr of fetch", last_rd_addr, line_addr);
            check("mem write count", mem_writes - writes0, kind == kind_miss_dirty);
            if (kind == kind_miss_dirty) begin
                check("mem_addr of write-back", last_wr_addr, wb_addr);
                check("write-back before fetch", last_wr_cycle < last_rd_cycle, 1'b1);
            end
        end
    endtask

    initial begin
        logic [`DCACHE_ADDR_W-1:0] addr;
        word_t mask;
        void'($urandom(32'h28d8_a47f));
        reset_n   = 1'b0;
        req_valid = 1'b0;
        req_addr  = '0;
        req_write = 1'b0;
        req_wdata = '0;
        req_wmask = '0;
        mem_ready = 1'b0;
        mem_done  = 1'b0;
        mem_rdata = '0;
        repeat (10) @(posedge clock);
        reset_n <= 1'b1;
        @(posedge clock);
        check("req_ready", req_ready, 1'b1);
        check("resp_done", resp_done, 1'b0);
        check("mem_valid", mem_valid, 1'b0);

        run_access(make_addr(1, 16, 3), 1'b0, '0, '0, kind_miss_clean, '0);
        run_access(make_addr(1, 16, 6), 1'b0, '0, '0, kind_hit, '0);
        run_access(make_addr(1, 16, 5), 1'b1, 64'h0123_4567_89ab_cdef, '1, kind_hit, '0);
        run_access(make_addr(1, 16, 5), 1'b0, '0, '0, kind_hit, '0);
        run_access(make_addr(1, 16, 3), 1'b1, '1, 64'h00ff_0000_ffff_0000, kind_hit, '0);
        run_access(make_addr(1, 16, 3), 1'b0, '0, '0, kind_hit, '0);
        // third tag in set 16 evicts the dirty way 0, the fourth a clean way 1
        run_access(make_addr(2, 16, 0), 1'b0, '0, '0, kind_miss_clean, '0);
        run_access(make_addr(3, 16, 1), 1'b0, '0, '0, kind_miss_dirty, make_addr(1, 16, 0));
        run_access(make_addr(4, 16, 2), 1'b0, '0, '0, kind_miss_clean, '0);
        run_access(make_addr(3, 16, 7), 1'b0, '0, '0, kind_hit, '0);
        run_access(make_addr(5, 17, 2), 1'b1, 64'hfeed_f00d_dead_beef,
                   64'hffff_0000_ff00_00ff, kind_miss_clean, '0);
        run_access(make_addr(5, 17, 2), 1'b0, '0, '0, kind_hit, '0);

        for (int i = 0; i < 360; i++) begin
            addr = make_addr(17'(17'h100 + $urandom_range(3)), 9'($urandom_range(2)),
                             3'($urandom_range(7)));
            mask = $urandom_range(1) ? '1 : {$urandom, $urandom};
            run_access(addr, 1'($urandom_range(1)), {$urandom, $urandom}, mask, kind_any, '0);
        end

        repeat (5) @(posedge clock);
        if (dut0.props0.fails == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("TESTBENCH FAILED");
            $fatal(1, "assertion failures");
        end
    end

endmodule

// ==== compile.f ====
+incdir+hdl
hdl/dcache_pkg.sv
hdl/dcache_sram.sv
hdl/dcache_ifs.sv
hdl/dcache_tag_lookup.sv
hdl/dcache_data_store.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
verif/dcache_properties.sv
verif/dcache_tb.sv
